/* rv_cfg.svh */
`ifndef RV_CFG_SVH
`define RV_CFG_SVH

// pc value after reset
`define RV_RESET_PC 32'h8000_0000

// data path width
`define RV_XLEN 32

// instruction word width
`define RV_ILEN 32

// register file size and address width
`define RV_NREGS 32
`define RV_REG_AW 5

`endif

/* rv_isa_pkg.sv */
`default_nettype none

package rv_isa_pkg;

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OP_IMM = 7'b001_0011,
    LUI    = 7'b011_0111,
    AUIPC  = 7'b001_0111,
    JAL    = 7'b110_1111,
    JALR   = 7'b110_0111,
    LOAD   = 7'b000_0011,
    STORE  = 7'b010_0011,
    SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 codes of loads and stores
  typedef enum logic [2:0] {
    SZ_B  = 3'b000,
    SZ_H  = 3'b001,
    SZ_W  = 3'b010,
    SZ_BU = 3'b100,
    SZ_HU = 3'b101
  } mem_size_e;

  // r-type layout, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_e    opcode;
  } inst_fields_t;

endpackage

`default_nettype wire

/* core_pkg.sv */
`default_nettype none

`include "rv_cfg.svh"

package core_pkg;

  // where the register write data comes from
  typedef enum logic [1:0] {
    WB_ADD  = 2'd0,
    WB_LINK = 2'd1,
    WB_LOAD = 2'd2
  } wb_sel_e;

  // decoded control for one instruction
  typedef struct packed {
    logic [`RV_REG_AW-1:0] rs1;
    logic [`RV_REG_AW-1:0] rs2;
    logic [`RV_REG_AW-1:0] rd;
    logic [`RV_XLEN-1:0]   imm;
    logic                  use_pc;     // adder input a is pc
    logic                  reg_write;
    wb_sel_e               wb_sel;
    logic                  is_jump;
    logic                  is_load;
    logic                  is_store;
    rv_isa_pkg::mem_size_e mem_size;
    logic                  is_ebreak;
  } ctrl_t;

  // same cycle data memory request
  typedef struct packed {
    logic [`RV_XLEN-1:0]   addr;       // word aligned
    logic [`RV_XLEN-1:0]   wdata;      // already in its byte lane
    logic [`RV_XLEN/8-1:0] wmask;
    logic                  read;
    logic                  write;
  } dmem_req_t;

endpackage

`default_nettype wire

/* decoder.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module decoder (
  input  logic [`RV_ILEN-1:0] inst,
  output core_pkg::ctrl_t     ctrl
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  inst_fields_t        fields;
  logic [`RV_XLEN-1:0] imm_i;
  logic [`RV_XLEN-1:0] imm_s;
  logic [`RV_XLEN-1:0] imm_u;
  logic [`RV_XLEN-1:0] imm_j;
  logic                ebreak_match;

  assign fields = inst_fields_t'(inst);

  // sign extended immediates
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_u = {inst[31:12], 12'h000};    // already in the upper bits
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  // only the exact ebreak encoding stops the core
  assign ebreak_match = ({fields.funct7, fields.rs2} == 12'h001) &&
                        (fields.rs1 == '0) &&
                        (fields.funct3 == 3'b000) &&
                        (fields.rd == '0);

  always_comb begin
    ctrl          = '0;
    ctrl.rs1      = fields.rs1;
    ctrl.rs2      = fields.rs2;
    ctrl.rd       = fields.rd;
    ctrl.wb_sel   = WB_ADD;
    ctrl.mem_size = mem_size_e'(fields.funct3);

    case (fields.opcode)
      OP_IMM: begin
        // addi only, other funct3 codes fall through as nop
        if (fields.funct3 == 3'b000) begin
          ctrl.imm       = imm_i;
          ctrl.reg_write = 1'b1;
        end
      end
      LUI: begin
        ctrl.rs1       = '0;                // adder a reads x0
        ctrl.imm       = imm_u;
        ctrl.reg_write = 1'b1;
      end
      AUIPC: begin
        ctrl.imm       = imm_u;
        ctrl.use_pc    = 1'b1;
        ctrl.reg_write = 1'b1;
      end
      JAL: begin
        ctrl.imm       = imm_j;
        ctrl.use_pc    = 1'b1;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_LINK;
        ctrl.is_jump   = 1'b1;
      end
      JALR: begin
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_LINK;
        ctrl.is_jump   = 1'b1;
      end
      LOAD: begin
        ctrl.imm       = imm_i;
        ctrl.reg_write = 1'b1;
        ctrl.wb_sel    = WB_LOAD;
        ctrl.is_load   = 1'b1;
      end
      STORE: begin
        ctrl.imm      = imm_s;
        ctrl.is_store = 1'b1;
      end
      SYSTEM: begin
        ctrl.is_ebreak = ebreak_match;    // ecall and csr ops are nops
      end
      default: begin
        // unknown opcode, pc just moves on
      end
    endcase
  end

endmodule

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module reg_file (
  input  logic                  clk,
  input  logic                  reset,
  input  logic [`RV_REG_AW-1:0] rs1_addr,
  input  logic [`RV_REG_AW-1:0] rs2_addr,
  input  logic                  wen,
  input  logic [`RV_REG_AW-1:0] waddr,
  input  logic [`RV_XLEN-1:0]   wdata,
  output logic [`RV_XLEN-1:0]   rs1_data,
  output logic [`RV_XLEN-1:0]   rs2_data
);

  // x0 has no storage
  logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < `RV_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  // write address must be resolved whenever a write is issued
  a_waddr_known: assert property (@(posedge clk) disable iff (reset)
    wen |-> !$isunknown(waddr))
    else $error("reg_file: write with unknown address");

endmodule

`default_nettype wire

/* exec_unit.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module exec_unit (
  input  logic                  clk,
  input  logic                  reset,
  input  core_pkg::ctrl_t       ctrl,
  input  logic [`RV_XLEN-1:0]   rs1_data,
  input  logic [`RV_XLEN-1:0]   load_data,
  output logic [`RV_XLEN-1:0]   pc,
  output logic [`RV_XLEN-1:0]   sum,
  output logic                  halt,
  output logic                  wen,
  output logic [`RV_REG_AW-1:0] waddr,
  output logic [`RV_XLEN-1:0]   wdata
);
  import core_pkg::*;

  logic [`RV_XLEN-1:0] pc_plus4;
  logic [`RV_XLEN-1:0] op_a;
  logic [`RV_XLEN-1:0] next_pc;

  assign pc_plus4 = pc + `RV_XLEN'd4;

  // the one adder: addresses, targets and addi/lui/auipc results
  assign op_a = ctrl.use_pc ? pc : rs1_data;
  assign sum  = op_a + ctrl.imm;

  always_comb begin
    case (ctrl.wb_sel)
      WB_LINK: wdata = pc_plus4;
      WB_LOAD: wdata = load_data;
      default: wdata = sum;
    endcase
  end

  assign wen   = ctrl.reg_write && !halt;   // nothing retires once halted
  assign waddr = ctrl.rd;

  always_comb begin
    if (halt || ctrl.is_ebreak) begin
      next_pc = pc;                          // park on the ebreak
    end else if (ctrl.is_jump) begin
      next_pc = {sum[`RV_XLEN-1:1], 1'b0};
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= `RV_RESET_PC;
      halt <= 1'b0;
    end else begin
      pc <= next_pc;
      if (ctrl.is_ebreak) begin
        halt <= 1'b1;                        // sticky until reset
      end
    end
  end

  a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
    pc[1:0] == 2'b00)
    else $error("exec_unit: pc not word aligned");

endmodule

`default_nettype wire

/* lsu.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module lsu (
  input  core_pkg::ctrl_t     ctrl,
  input  logic                halt,
  input  logic [`RV_XLEN-1:0] addr,
  input  logic [`RV_XLEN-1:0] rs2_data,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output core_pkg::dmem_req_t dmem_req,
  output logic [`RV_XLEN-1:0] load_data
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic [1:0]          offset;
  logic                aligned;
  logic [`RV_XLEN-1:0] shifted;

  assign offset  = addr[1:0];
  assign shifted = dmem_rdata >> {offset, 3'b000};   // selected lane in the low bits

  // halves need an even address, words a multiple of four
  always_comb begin
    case (ctrl.mem_size)
      SZ_H, SZ_HU: aligned = !offset[0];
      SZ_W:        aligned = (offset == 2'b00);
      default:     aligned = 1'b1;
    endcase
  end

  always_comb begin
    dmem_req       = '0;
    dmem_req.addr  = {addr[`RV_XLEN-1:2], 2'b00};
    dmem_req.read  = ctrl.is_load && !halt;
    dmem_req.write = ctrl.is_store && !halt;    // no access once halted
    if (ctrl.is_store && aligned) begin
      dmem_req.wdata = rs2_data << {offset, 3'b000};
      case (ctrl.mem_size)
        SZ_B:    dmem_req.wmask = 4'b0001 << offset;
        SZ_H:    dmem_req.wmask = offset[1] ? 4'b1100 : 4'b0011;
        SZ_W:    dmem_req.wmask = 4'b1111;
        default: dmem_req.wmask = '0;
      endcase
    end
  end

  // misaligned loads return zero
  always_comb begin
    load_data = '0;
    if (aligned) begin
      case (ctrl.mem_size)
        SZ_B:    load_data = {{(`RV_XLEN-8){shifted[7]}}, shifted[7:0]};
        SZ_H:    load_data = {{(`RV_XLEN-16){shifted[15]}}, shifted[15:0]};
        SZ_BU:   load_data = {{(`RV_XLEN-8){1'b0}}, shifted[7:0]};
        SZ_HU:   load_data = {{(`RV_XLEN-16){1'b0}}, shifted[15:0]};
        default: load_data = dmem_rdata;
      endcase
    end
  end

  // a request is a load or a store, never both
  always_comb begin
    a_rw_exclusive: assert ((dmem_req.read & dmem_req.write) !== 1'b1)
      else $error("lsu: read and write in the same request");
  end

endmodule

`default_nettype wire

/* rv_core_top.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module rv_core_top (
  input  logic                clk,
  input  logic                reset,
  input  logic [`RV_ILEN-1:0] inst,
  input  logic [`RV_XLEN-1:0] dmem_rdata,
  output logic [`RV_XLEN-1:0] pc,
  output core_pkg::dmem_req_t dmem_req,
  output logic                halt
);
  import core_pkg::*;

  ctrl_t                 ctrl;
  logic [`RV_XLEN-1:0]   rs1_data;
  logic [`RV_XLEN-1:0]   rs2_data;
  logic [`RV_XLEN-1:0]   sum;          // effective address for lsu
  logic [`RV_XLEN-1:0]   load_data;
  logic                  wen;
  logic [`RV_REG_AW-1:0] waddr;
  logic [`RV_XLEN-1:0]   wdata;

  decoder i_decoder (
    .inst (inst),
    .ctrl (ctrl)
  );

  reg_file i_reg_file (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (ctrl.rs1),
    .rs2_addr (ctrl.rs2),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exec_unit i_exec_unit (
    .clk       (clk),
    .reset     (reset),
    .ctrl      (ctrl),
    .rs1_data  (rs1_data),
    .load_data (load_data),
    .pc        (pc),
    .sum       (sum),
    .halt      (halt),
    .wen       (wen),
    .waddr     (waddr),
    .wdata     (wdata)
  );

  lsu i_lsu (
    .ctrl       (ctrl),
    .halt       (halt),
    .addr       (sum),
    .rs2_data   (rs2_data),
    .dmem_rdata (dmem_rdata),
    .dmem_req   (dmem_req),
    .load_data  (load_data)
  );

endmodule

`default_nettype wire

/* tb_rv_core.sv */
`timescale 1ns/10ps
`default_nettype none

`include "rv_cfg.svh"

module tb_rv_core;
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int DRIVE_DELAY  = 1;
  localparam int FIELDS       = 8;     // words per trace line
  localparam int MAX_STEPS    = 128;
  localparam int HALT_TIMEOUT = 20;

  localparam logic [`RV_ILEN-1:0] NOP = 32'h0000_0013;   // addi x0, x0, 0

  // one trace line, as read from the data file
  typedef struct packed {
    logic [`RV_ILEN-1:0]   inst;
    logic [`RV_XLEN-1:0]   rdata;
    logic                  write;
    logic [`RV_XLEN-1:0]   addr;
    logic [`RV_XLEN/8-1:0] wmask;
    logic [`RV_XLEN-1:0]   wdata;
    logic [`RV_XLEN-1:0]   pc;
    logic                  halt;
  } step_t;

  logic                clk;
  logic                reset;
  logic [`RV_ILEN-1:0] inst;
  logic [`RV_XLEN-1:0] dmem_rdata;
  logic [`RV_XLEN-1:0] pc;
  dmem_req_t           dmem_req;
  logic                halt;

  logic [31:0] trace_mem [0:FIELDS*MAX_STEPS];   // word 0 holds the step count
  int          num_steps;
  int          errors;

  rv_core_top i_rv_core_top (
    .clk        (clk),
    .reset      (reset),
    .inst       (inst),
    .dmem_rdata (dmem_rdata),
    .pc         (pc),
    .dmem_req   (dmem_req),
    .halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  function automatic step_t fetch_step(input int step);
    int    base;
    step_t st;
    base     = 1 + step * FIELDS;
    st.inst  = trace_mem[base];
    st.rdata = trace_mem[base + 1];
    st.write = trace_mem[base + 2][0];
    st.addr  = trace_mem[base + 3];
    st.wmask = trace_mem[base + 4][`RV_XLEN/8-1:0];
    st.wdata = trace_mem[base + 5];
    st.pc    = trace_mem[base + 6];
    st.halt  = trace_mem[base + 7][0];
    return st;
  endfunction

  initial begin
    step_t st;
    string tname;
    int    wait_cycles;
    logic  exp_read;
    logic  was_halted;

    errors     = 0;
    was_halted = 1'b0;
    reset      = 1'b1;
    inst       = NOP;              // keeps read and write low during reset
    dmem_rdata = '0;

    $readmemh("core_trace.txt", trace_mem);
    num_steps = trace_mem[0];
    if (num_steps <= 0 || num_steps > MAX_STEPS) begin
      $display("trace file holds no usable step count (%0d)", num_steps);
      errors++;
      num_steps = 0;
    end

    repeat (2) @(posedge clk);
    #DRIVE_DELAY;
    reset = 1'b0;

    if (pc !== `RV_RESET_PC) begin
      $display("[FAIL] reset pc: expected %h, actual %h", `RV_RESET_PC, pc);
      errors++;
    end
    if (halt !== 1'b0) begin
      $display("[FAIL] reset halt: expected 0, actual %b", halt);
      errors++;
    end

    for (int s = 0; s < num_steps; s++) begin
      st         = fetch_step(s);
      tname      = $sformatf("step %0d inst %h", s, st.inst);
      inst       = st.inst;
      dmem_rdata = st.rdata;
      exp_read   = (st.inst[6:0] == LOAD) && !was_halted;   // loads read until halted

      // request is combinational, sample it just before the edge
      #(CLK_PERIOD - 2*DRIVE_DELAY);
      if (dmem_req.read !== exp_read) begin
        $display("[FAIL] %s read: expected %b, actual %b", tname, exp_read, dmem_req.read);
        errors++;
      end
      if (dmem_req.write !== st.write) begin
        $display("[FAIL] %s write: expected %b, actual %b", tname, st.write, dmem_req.write);
        errors++;
      end
      if (st.write) begin
        if (dmem_req.addr !== st.addr) begin
          $display("[FAIL] %s addr: expected %h, actual %h", tname, st.addr, dmem_req.addr);
          errors++;
        end
        if (dmem_req.wmask !== st.wmask) begin
          $display("[FAIL] %s wmask: expected %h, actual %h",
                   tname, st.wmask, dmem_req.wmask);
          errors++;
        end
        if (dmem_req.wdata !== st.wdata) begin
          $display("[FAIL] %s wdata: expected %h, actual %h",
                   tname, st.wdata, dmem_req.wdata);
          errors++;
        end
      end

      @(posedge clk);
      #DRIVE_DELAY;
      // retired state after the edge
      if (pc !== st.pc) begin
        $display("[FAIL] %s pc: expected %h, actual %h", tname, st.pc, pc);
        errors++;
      end
      if (halt !== st.halt) begin
        $display("[FAIL] %s halt: expected %b, actual %b", tname, st.halt, halt);
        errors++;
      end
      was_halted = st.halt;
    end

    inst       = NOP;
    dmem_rdata = '0;

    // the trace ends on an ebreak, so halt should already be up
    wait_cycles = 0;
    while (halt !== 1'b1 && wait_cycles < HALT_TIMEOUT) begin
      @(posedge clk);
      #DRIVE_DELAY;
      wait_cycles++;
    end
    if (halt !== 1'b1) begin
      $display("halt did not rise within %0d cycles after the trace ended", HALT_TIMEOUT);
      errors++;
    end

    $display("steps run: %0d, errors: %0d", num_steps, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* core_trace.txt */
// columns: inst  rdata  write  addr  wmask  wdata  pc_after  halt_after
// first word is the number of steps; addr, wmask and wdata only matter when write is 1
37 // step count
00000013 00000000 0 00000000 0 00000000 80000004 0 // nop
12300093 00000000 0 00000000 0 00000000 80000008 0 // addi x1, x0, 0x123
10102023 00000000 1 00000100 f 00000123 8000000c 0 // sw x1, 0x100
ffb08113 00000000 0 00000000 0 00000000 80000010 0 // addi x2, x1, -5
10202223 00000000 1 00000104 f 0000011e 80000014 0 // sw x2, 0x104
abcde1b7 00000000 0 00000000 0 00000000 80000018 0 // lui x3, 0xabcde
10302423 00000000 1 00000108 f abcde000 8000001c 0 // sw x3, 0x108
12345217 00000000 0 00000000 0 00000000 80000020 0 // auipc x4, 0x12345
10402623 00000000 1 0000010c f 9234501c 80000024 0 // sw x4, 0x10c
010002ef 00000000 0 00000000 0 00000000 80000034 0 // jal x5, +16
10502823 00000000 1 00000110 f 80000028 80000038 0 // sw x5, 0x110
029283e7 00000000 0 00000000 0 00000000 80000050 0 // jalr x7, 0x29(x5)
10702a23 00000000 1 00000114 f 8000003c 80000054 0 // sw x7, 0x114
20000403 81f27e93 0 00000000 0 00000000 80000058 0 // lb x8, 0x200
12802023 00000000 1 00000120 f ffffff93 8000005c 0 // sw x8, 0x120
20100403 81f27e93 0 00000000 0 00000000 80000060 0 // lb x8, 0x201
12802023 00000000 1 00000120 f 0000007e 80000064 0
20200403 81f27e93 0 00000000 0 00000000 80000068 0 // lb x8, 0x202
12802023 00000000 1 00000120 f fffffff2 8000006c 0
20300403 81f27e93 0 00000000 0 00000000 80000070 0 // lb x8, 0x203
12802023 00000000 1 00000120 f ffffff81 80000074 0
20004403 81f27e93 0 00000000 0 00000000 80000078 0 // lbu x8, 0x200
12802023 00000000 1 00000120 f 00000093 8000007c 0
20104403 81f27e93 0 00000000 0 00000000 80000080 0 // lbu x8, 0x201
12802023 00000000 1 00000120 f 0000007e 80000084 0
20204403 81f27e93 0 00000000 0 00000000 80000088 0 // lbu x8, 0x202
12802023 00000000 1 00000120 f 000000f2 8000008c 0
20304403 81f27e93 0 00000000 0 00000000 80000090 0 // lbu x8, 0x203
12802023 00000000 1 00000120 f 00000081 80000094 0
20001403 81f27e93 0 00000000 0 00000000 80000098 0 // lh x8, 0x200
12802023 00000000 1 00000120 f 00007e93 8000009c 0
20201403 81f27e93 0 00000000 0 00000000 800000a0 0 // lh x8, 0x202
12802023 00000000 1 00000120 f ffff81f2 800000a4 0
20005403 81f27e93 0 00000000 0 00000000 800000a8 0 // lhu x8, 0x200
12802023 00000000 1 00000120 f 00007e93 800000ac 0
20205403 81f27e93 0 00000000 0 00000000 800000b0 0 // lhu x8, 0x202
12802023 00000000 1 00000120 f 000081f2 800000b4 0
20002403 81f27e93 0 00000000 0 00000000 800000b8 0 // lw x8, 0x200
12802023 00000000 1 00000120 f 81f27e93 800000bc 0
20101403 81f27e93 0 00000000 0 00000000 800000c0 0 // lh x8, 0x201 misaligned
12802023 00000000 1 00000120 f 00000000 800000c4 0
112234b7 00000000 0 00000000 0 00000000 800000c8 0 // lui x9, 0x11223
34448493 00000000 0 00000000 0 00000000 800000cc 0 // addi x9, x9, 0x344
30900023 00000000 1 00000300 1 11223344 800000d0 0 // sb x9, 0x300
309000a3 00000000 1 00000300 2 22334400 800000d4 0 // sb x9, 0x301
30900123 00000000 1 00000300 4 33440000 800000d8 0 // sb x9, 0x302
309001a3 00000000 1 00000300 8 44000000 800000dc 0 // sb x9, 0x303
30901023 00000000 1 00000300 3 11223344 800000e0 0 // sh x9, 0x300
30901123 00000000 1 00000300 c 33440000 800000e4 0 // sh x9, 0x302
309010a3 00000000 1 00000300 0 00000000 800000e8 0 // sh x9, 0x301 misaligned
30902223 00000000 1 00000304 f 11223344 800000ec 0 // sw x9, 0x304
00100073 00000000 0 00000000 0 00000000 800000ec 1 // ebreak
30902223 00000000 0 00000000 0 00000000 800000ec 1 // sw after halt
12300093 00000000 0 00000000 0 00000000 800000ec 1 // addi after halt
10102023 00000000 0 00000000 0 00000000 800000ec 1 // sw after halt

/* tb.f */
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
decoder.sv
reg_file.sv
exec_unit.sv
lsu.sv
rv_core_top.sv
tb_rv_core.sv

/* Makefile */
# Verilator build and run of the trace-driven core testbench

.PHONY: all run lint clean

all: run

obj_dir/Vtb_rv_core: tb.f $(wildcard *.sv *.svh)
	verilator --binary --assert --timescale 1ns/10ps -f tb.f --top-module tb_rv_core

run: obj_dir/Vtb_rv_core
	./obj_dir/Vtb_rv_core > sim.log 2>&1; cat sim.log
	@if grep -q ">>> FAIL" sim.log; then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q ">>> PASS" sim.log; then echo "simulation ended without a result"; exit 1; fi

lint:
	verilator --lint-only -Wall --timescale 1ns/10ps +incdir+. \
	  rv_isa_pkg.sv core_pkg.sv decoder.sv reg_file.sv exec_unit.sv lsu.sv rv_core_top.sv \
	  --top-module rv_core_top

clean:
	rm -rf obj_dir sim.log
